// File: source/ring_pkg.sv
package ring_pkg;

    // ------------------------------------------------------------------
    // packet format
    // ------------------------------------------------------------------
    localparam int WORD_W = 64;

    typedef logic [WORD_W-1:0] flit_t;

    // polarity stamp, set on acceptance
    localparam int POL_BIT = 63;
    // 1 = clockwise, 0 = counterclockwise
    localparam int DIR_BIT = 62;

    // hop field, thermometer coded, shifted once per switch
    localparam int HOP_LSB = 48;
    localparam int HOP_W   = 8;

    // legal hop codes at pe injection
    localparam logic [HOP_W-1:0] HOP_ONE   = 8'h01;
    localparam logic [HOP_W-1:0] HOP_TWO   = 8'h03;
    localparam logic [HOP_W-1:0] HOP_THREE = 8'h07;

    // ------------------------------------------------------------------
    // ports and arbitration
    // ------------------------------------------------------------------
    localparam int NUM_PORTS = 3;

    typedef enum logic [1:0] {
        PORT_CW  = 2'd0,
        PORT_CCW = 2'd1,
        PORT_PE  = 2'd2
    } port_e;

    // which request side wins a tie
    typedef enum logic {
        PRIO_FIRST  = 1'b0,
        PRIO_SECOND = 1'b1
    } prio_e;

endpackage

// File: source/plane_link_if.sv
interface plane_link_if;

    // link side, written by the steering logic
    ring_pkg::flit_t in_data [ring_pkg::NUM_PORTS];
    logic [ring_pkg::NUM_PORTS-1:0] in_wen;
    logic [ring_pkg::NUM_PORTS-1:0] out_ren;
    // high while this plane is in its switch phase
    logic switch_en;

    // buffer status and output contents from the plane
    logic [ring_pkg::NUM_PORTS-1:0] in_empty;
    logic [ring_pkg::NUM_PORTS-1:0] out_full;
    ring_pkg::flit_t out_data [ring_pkg::NUM_PORTS];

    modport steer (
        output in_data,
        output in_wen,
        output out_ren,
        output switch_en,
        input  in_empty,
        input  out_full,
        input  out_data
    );

    modport plane (
        input  in_data,
        input  in_wen,
        input  out_ren,
        input  switch_en,
        output in_empty,
        output out_full,
        output out_data
    );

endinterface

// File: source/slot_buffer.sv
module slot_buffer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            we,
    input  logic            re,
    input  ring_pkg::flit_t data_in,
    output ring_pkg::flit_t data_out,
    output logic            full,
    output logic            empty
);

    logic            valid;
    ring_pkg::flit_t slot;

    // valid flag, write wins over read in the same edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (we) begin
            valid <= 1'b1;
        end else if (re) begin
            valid <= 1'b0;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (we) begin
            slot <= data_in;
        end
    end

    assign data_out = slot;
    assign full     = valid;
    assign empty    = ~valid;

    // callers must not overwrite a held packet or read an empty slot
    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        !(we && valid && !re));
    a_no_underrun: assert property (@(posedge clk) disable iff (!rst_n)
        !(re && !valid));

endmodule

// File: source/rr_arbiter.sv
module rr_arbiter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [1:0] req,
    output logic [1:0] grant
);

    ring_pkg::prio_e prio;

    // favored side wins, other side only when favored one is idle
    always_comb begin
        if (prio == ring_pkg::PRIO_FIRST) begin
            grant[0] = req[0];
            grant[1] = req[1] & ~req[0];
        end else begin
            grant[1] = req[1];
            grant[0] = req[0] & ~req[1];
        end
    end

    // hand priority to the side that did not just win
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio <= ring_pkg::PRIO_FIRST;
        end else if (grant[0]) begin
            prio <= ring_pkg::PRIO_SECOND;
        end else if (grant[1]) begin
            prio <= ring_pkg::PRIO_FIRST;
        end
    end

    // at most one winner, and only among the requesters
    a_grant_legal: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && ((grant & ~req) == 2'b00));

endmodule

// File: source/vc_plane.sv
module vc_plane (
    input logic         clk,
    input logic         rst_n,
    plane_link_if.plane link
);

    localparam int NP = ring_pkg::NUM_PORTS;

    logic [NP-1:0]   in_full;
    logic [NP-1:0]   in_ren;
    logic [NP-1:0]   out_empty;
    logic [NP-1:0]   out_wen;
    ring_pkg::flit_t head    [NP];
    ring_pkg::flit_t shifted [NP];
    ring_pkg::flit_t out_din [NP];
    ring_pkg::port_e target  [NP];
    logic [1:0]      req_cw, req_ccw, req_pe;
    logic [1:0]      gnt_cw, gnt_ccw, gnt_pe;

    // ------------------------------------------------------------------
    // input and output slots, one pair per port
    // ------------------------------------------------------------------
    for (genvar p = 0; p < NP; p++) begin : g_port
        slot_buffer in_buf (
            .clk      (clk),
            .rst_n    (rst_n),
            .we       (link.in_wen[p]),
            .re       (in_ren[p]),
            .data_in  (link.in_data[p]),
            .data_out (head[p]),
            .full     (in_full[p]),
            .empty    (link.in_empty[p])
        );

        slot_buffer out_buf (
            .clk      (clk),
            .rst_n    (rst_n),
            .we       (out_wen[p]),
            .re       (link.out_ren[p]),
            .data_in  (out_din[p]),
            .data_out (link.out_data[p]),
            .full     (link.out_full[p]),
            .empty    (out_empty[p])
        );

        // one hop consumed per switch transfer
        always_comb begin
            shifted[p] = head[p];
            shifted[p][ring_pkg::HOP_LSB +: ring_pkg::HOP_W] =
                head[p][ring_pkg::HOP_LSB +: ring_pkg::HOP_W] >> 1;
        end
    end

    // ------------------------------------------------------------------
    // routing and requests
    // ------------------------------------------------------------------
    // ring traffic keeps going while hop bit 0 is set, else ejects to pe
    assign target[ring_pkg::PORT_CW]  = head[ring_pkg::PORT_CW][ring_pkg::HOP_LSB] ?
                                        ring_pkg::PORT_CW : ring_pkg::PORT_PE;
    assign target[ring_pkg::PORT_CCW] = head[ring_pkg::PORT_CCW][ring_pkg::HOP_LSB] ?
                                        ring_pkg::PORT_CCW : ring_pkg::PORT_PE;
    // injected traffic follows its direction bit
    assign target[ring_pkg::PORT_PE]  = head[ring_pkg::PORT_PE][ring_pkg::DIR_BIT] ?
                                        ring_pkg::PORT_CW : ring_pkg::PORT_CCW;

    always_comb begin
        req_cw = '0;
        req_ccw = '0;
        req_pe = '0;
        if (link.switch_en) begin
            // cw out: cw input first side, pe input second
            req_cw[0]  = in_full[ring_pkg::PORT_CW] && out_empty[ring_pkg::PORT_CW] &&
                         target[ring_pkg::PORT_CW] == ring_pkg::PORT_CW;
            req_cw[1]  = in_full[ring_pkg::PORT_PE] && out_empty[ring_pkg::PORT_CW] &&
                         target[ring_pkg::PORT_PE] == ring_pkg::PORT_CW;
            // ccw out: ccw input, pe input
            req_ccw[0] = in_full[ring_pkg::PORT_CCW] && out_empty[ring_pkg::PORT_CCW] &&
                         target[ring_pkg::PORT_CCW] == ring_pkg::PORT_CCW;
            req_ccw[1] = in_full[ring_pkg::PORT_PE] && out_empty[ring_pkg::PORT_CCW] &&
                         target[ring_pkg::PORT_PE] == ring_pkg::PORT_CCW;
            // pe out: cw input, ccw input
            req_pe[0]  = in_full[ring_pkg::PORT_CW] && out_empty[ring_pkg::PORT_PE] &&
                         target[ring_pkg::PORT_CW] == ring_pkg::PORT_PE;
            req_pe[1]  = in_full[ring_pkg::PORT_CCW] && out_empty[ring_pkg::PORT_PE] &&
                         target[ring_pkg::PORT_CCW] == ring_pkg::PORT_PE;
        end
    end

    // ------------------------------------------------------------------
    // one arbiter per output
    // ------------------------------------------------------------------
    rr_arbiter cw_arb  (.clk(clk), .rst_n(rst_n), .req(req_cw),  .grant(gnt_cw));
    rr_arbiter ccw_arb (.clk(clk), .rst_n(rst_n), .req(req_ccw), .grant(gnt_ccw));
    rr_arbiter pe_arb  (.clk(clk), .rst_n(rst_n), .req(req_pe),  .grant(gnt_pe));

    // grant moves the head across, same edge
    assign out_wen[ring_pkg::PORT_CW]  = |gnt_cw;
    assign out_wen[ring_pkg::PORT_CCW] = |gnt_ccw;
    assign out_wen[ring_pkg::PORT_PE]  = |gnt_pe;

    assign out_din[ring_pkg::PORT_CW]  = gnt_cw[1]  ? shifted[ring_pkg::PORT_PE] :
                                                      shifted[ring_pkg::PORT_CW];
    assign out_din[ring_pkg::PORT_CCW] = gnt_ccw[1] ? shifted[ring_pkg::PORT_PE] :
                                                      shifted[ring_pkg::PORT_CCW];
    assign out_din[ring_pkg::PORT_PE]  = gnt_pe[1]  ? shifted[ring_pkg::PORT_CCW] :
                                                      shifted[ring_pkg::PORT_CW];

    assign in_ren[ring_pkg::PORT_CW]  = gnt_cw[0] | gnt_pe[0];
    assign in_ren[ring_pkg::PORT_CCW] = gnt_ccw[0] | gnt_pe[1];
    assign in_ren[ring_pkg::PORT_PE]  = gnt_cw[1] | gnt_ccw[1];

    // links stay off this plane while it switches
    a_link_idle_in_switch: assert property (@(posedge clk) disable iff (!rst_n)
        link.switch_en |-> (link.in_wen == '0 && link.out_ren == '0));

endmodule

// File: source/phase_steer.sv
module phase_steer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            polarity,
    input  ring_pkg::flit_t cwdi,
    input  ring_pkg::flit_t ccwdi,
    input  ring_pkg::flit_t pedi,
    input  logic            cwsi,
    input  logic            ccwsi,
    input  logic            pesi,
    input  logic            cwro,
    input  logic            ccwro,
    input  logic            pero,
    output logic            cwri,
    output logic            ccwri,
    output logic            peri,
    output logic            cwso,
    output logic            ccwso,
    output logic            peso,
    output ring_pkg::flit_t cwdo,
    output ring_pkg::flit_t ccwdo,
    output ring_pkg::flit_t pedo,
    plane_link_if.steer     even_link,
    plane_link_if.steer     odd_link
);

    localparam int NP = ring_pkg::NUM_PORTS;

    logic [NP-1:0]   send_in, ready_in, send_out, ready_out;
    logic [NP-1:0]   wen, ren;
    ring_pkg::flit_t in_flit [NP];
    ring_pkg::flit_t pe_stamped;
    logic            pe_ok;

    // ------------------------------------------------------------------
    // polarity stamp and pe injection check
    // ------------------------------------------------------------------
    always_comb begin
        in_flit[ring_pkg::PORT_CW] = cwdi;
        in_flit[ring_pkg::PORT_CW][ring_pkg::POL_BIT] = polarity;
        in_flit[ring_pkg::PORT_CCW] = ccwdi;
        in_flit[ring_pkg::PORT_CCW][ring_pkg::POL_BIT] = polarity;
        pe_stamped = pedi;
        pe_stamped[ring_pkg::POL_BIT] = polarity;

        in_flit[ring_pkg::PORT_PE] = pe_stamped;
        pe_ok = 1'b0;
        case (pe_stamped[ring_pkg::HOP_LSB +: ring_pkg::HOP_W])
            ring_pkg::HOP_ONE: pe_ok = 1'b1;
            ring_pkg::HOP_TWO: begin
                // two hops always go clockwise
                in_flit[ring_pkg::PORT_PE][ring_pkg::DIR_BIT] = 1'b1;
                pe_ok = 1'b1;
            end
            ring_pkg::HOP_THREE: begin
                // shorter the other way round, one hop
                in_flit[ring_pkg::PORT_PE][ring_pkg::DIR_BIT] =
                    ~pe_stamped[ring_pkg::DIR_BIT];
                in_flit[ring_pkg::PORT_PE][ring_pkg::HOP_LSB +: ring_pkg::HOP_W] =
                    ring_pkg::HOP_ONE;
                pe_ok = 1'b1;
            end
            // bad hop code, packet dropped
            default: pe_ok = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // link handshake against the active plane
    // ------------------------------------------------------------------
    assign send_in  = {pesi, ccwsi, cwsi};
    assign ready_out = {pero, ccwro, cwro};

    // polarity 0 selects even
    assign ready_in = polarity ? odd_link.in_empty : even_link.in_empty;
    assign send_out = polarity ? odd_link.out_full : even_link.out_full;

    assign wen = send_in & ready_in & {pe_ok, 2'b11};
    assign ren = send_out & ready_out;

    assign even_link.in_data   = in_flit;
    assign odd_link.in_data    = in_flit;
    assign even_link.in_wen    = polarity ? '0 : wen;
    assign odd_link.in_wen     = polarity ? wen : '0;
    assign even_link.out_ren   = polarity ? '0 : ren;
    assign odd_link.out_ren    = polarity ? ren : '0;
    // the idle plane switches
    assign even_link.switch_en = polarity;
    assign odd_link.switch_en  = ~polarity;

    assign cwri  = ready_in[ring_pkg::PORT_CW];
    assign ccwri = ready_in[ring_pkg::PORT_CCW];
    assign peri  = ready_in[ring_pkg::PORT_PE];
    assign cwso  = send_out[ring_pkg::PORT_CW];
    assign ccwso = send_out[ring_pkg::PORT_CCW];
    assign peso  = send_out[ring_pkg::PORT_PE];

    // data out shows the active plane's output slots
    assign cwdo  = polarity ? odd_link.out_data[ring_pkg::PORT_CW] :
                              even_link.out_data[ring_pkg::PORT_CW];
    assign ccwdo = polarity ? odd_link.out_data[ring_pkg::PORT_CCW] :
                              even_link.out_data[ring_pkg::PORT_CCW];
    assign pedo  = polarity ? odd_link.out_data[ring_pkg::PORT_PE] :
                              even_link.out_data[ring_pkg::PORT_PE];

    // only one plane talks to the links at a time
    a_one_link_plane: assert property (@(posedge clk) disable iff (!rst_n)
        !(|{even_link.in_wen, even_link.out_ren} && |{odd_link.in_wen, odd_link.out_ren}));

endmodule

// File: source/gold_router.sv
module gold_router (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            polarity,
    // clockwise in
    input  ring_pkg::flit_t cwdi,
    input  logic            cwsi,
    output logic            cwri,
    // counterclockwise in
    input  ring_pkg::flit_t ccwdi,
    input  logic            ccwsi,
    output logic            ccwri,
    // processing element in
    input  ring_pkg::flit_t pedi,
    input  logic            pesi,
    output logic            peri,
    // clockwise out
    output ring_pkg::flit_t cwdo,
    output logic            cwso,
    input  logic            cwro,
    // counterclockwise out
    output ring_pkg::flit_t ccwdo,
    output logic            ccwso,
    input  logic            ccwro,
    // processing element out
    output ring_pkg::flit_t pedo,
    output logic            peso,
    input  logic            pero
);

    plane_link_if even_link ();
    plane_link_if odd_link ();

    // two virtual channel planes, alternating link and switch phases
    vc_plane even_plane (.clk(clk), .rst_n(rst_n), .link(even_link.plane));
    vc_plane odd_plane  (.clk(clk), .rst_n(rst_n), .link(odd_link.plane));

    phase_steer steer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .polarity  (polarity),
        .cwdi      (cwdi),
        .ccwdi     (ccwdi),
        .pedi      (pedi),
        .cwsi      (cwsi),
        .ccwsi     (ccwsi),
        .pesi      (pesi),
        .cwro      (cwro),
        .ccwro     (ccwro),
        .pero      (pero),
        .cwri      (cwri),
        .ccwri     (ccwri),
        .peri      (peri),
        .cwso      (cwso),
        .ccwso     (ccwso),
        .peso      (peso),
        .cwdo      (cwdo),
        .ccwdo     (ccwdo),
        .pedo      (pedo),
        .even_link (even_link.steer),
        .odd_link  (odd_link.steer)
    );

endmodule

// File: sim/router_checker.sv
module router_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   polarity,
    input  logic [2:0]             so,
    input  logic [2:0]             ro,
    input  ring_pkg::flit_t        cw_dout,
    input  ring_pkg::flit_t        ccw_dout,
    input  ring_pkg::flit_t        pe_dout,
    // one expectation lane per input port
    input  logic [2:0]             exp_valid,
    input  logic [2:0][1:0]        exp_port,
    input  logic [2:0][63:0]       exp_data,
    input  logic                   any_order,
    input  logic                   test_end,
    input  logic [8*16-1:0]        test_name,
    output int                     pending,
    output int                     tests_passed,
    output int                     tests_failed
);
    timeunit 1ns;
    timeprecision 1ps;

    ring_pkg::flit_t exp_q [3][$];
    ring_pkg::flit_t dout [3];
    // per port and plane, packet seen waiting on a low ro
    logic            held [3][2];
    ring_pkg::flit_t held_data [3][2];
    int              test_errs;

    assign dout[0] = cw_dout;
    assign dout[1] = ccw_dout;
    assign dout[2] = pe_dout;

    function automatic string out_name(input int p);
        if (p == 0) return "cwdo";
        if (p == 1) return "ccwdo";
        return "pedo";
    endfunction

    initial begin
        pending = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_errs = 0;
    end

    always @(posedge clk) begin : watch
        int  idx;
        bit  found;
        int  pol;
        pol = int'(polarity);
        if (!rst_n) begin
            for (int p = 0; p < 3; p++) begin
                held[p][0] = 1'b0;
                held[p][1] = 1'b0;
                exp_q[p].delete();
            end
        end else begin
            // packets accepted on this edge
            for (int l = 0; l < 3; l++) begin
                if (exp_valid[l]) begin
                    exp_q[exp_port[l]].push_back(exp_data[l]);
                end
            end
            for (int p = 0; p < 3; p++) begin
                // back-pressure: strobe and data hold until taken
                if (held[p][pol] && !so[p]) begin
                    $display("Error at %0t ns: send for %s fell before the packet was taken",
                             $time, out_name(p));
                    test_errs++;
                end else if (held[p][pol] && dout[p] != held_data[p][pol]) begin
                    $display("Error at %0t ns: %s expected %h got %h",
                             $time, out_name(p), held_data[p][pol], dout[p]);
                    test_errs++;
                end
                held[p][pol] = so[p] && !ro[p];
                held_data[p][pol] = dout[p];
                // delivery
                if (so[p] && ro[p]) begin
                    found = 1'b0;
                    if (exp_q[p].size() == 0) begin
                        $display("Error at %0t ns: unexpected packet %h on %s",
                                 $time, dout[p], out_name(p));
                        test_errs++;
                    end else if (exp_q[p][0] == dout[p]) begin
                        void'(exp_q[p].pop_front());
                    end else begin
                        // set comparison for contention tests
                        if (any_order) begin
                            for (idx = 0; idx < exp_q[p].size(); idx++) begin
                                if (!found && exp_q[p][idx] == dout[p]) begin
                                    exp_q[p].delete(idx);
                                    found = 1'b1;
                                end
                            end
                        end
                        if (!found) begin
                            $display("Error at %0t ns: %s expected %h got %h",
                                     $time, out_name(p), exp_q[p][0], dout[p]);
                            void'(exp_q[p].pop_front());
                            test_errs++;
                        end
                    end
                end
            end
            if (test_end) begin
                for (int p = 0; p < 3; p++) begin
                    if (exp_q[p].size() != 0) begin
                        $display("%0d packet(s) never delivered on %s",
                                 exp_q[p].size(), out_name(p));
                        test_errs++;
                        exp_q[p].delete();
                    end
                end
                if (test_errs == 0) begin
                    $display("test %0s: pass", test_name);
                    tests_passed++;
                end else begin
                    $display("test %0s: FAIL with %0d errors", test_name, test_errs);
                    tests_failed++;
                end
                test_errs = 0;
            end
        end
        pending = exp_q[0].size() + exp_q[1].size() + exp_q[2].size();
    end

endmodule

// File: sim/tb_router.sv
module tb_router;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = 15;
    localparam int LIMIT = 16 + 40 * N + 50;

    logic                clk;
    logic                rst_n;
    logic                polarity;
    logic [2:0]          si_v;
    logic [2:0]          ro_v;
    ring_pkg::flit_t     di_v [3];
    logic                cwri, ccwri, peri;
    logic [2:0]          ri_v;
    logic                cwso, ccwso, peso;
    ring_pkg::flit_t     cwdo, ccwdo, pedo;
    logic [2:0]          exp_valid;
    logic [2:0][1:0]     exp_port;
    logic [2:0][63:0]    exp_data;
    logic                any_order;
    logic                test_end;
    logic [8*16-1:0]     test_name;
    int                  pending, tests_passed, tests_failed;
    int                  seed;
    int                  cycles;
    int                  tb_errors;
    int                  n_entries;

    // ------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------
    logic [8*16-1:0]     t_name [N];
    ring_pkg::port_e     t_port [N];
    ring_pkg::port_e     t_dest [N];
    ring_pkg::flit_t     t_pkt [N];
    int                  t_hold [N];
    bit                  t_drop [N];
    bit                  t_next [N];
    bit                  t_any [N];
    bit                  t_bp [N];
    bit                  sent [N];

    gold_router dut_i (
        .clk(clk), .rst_n(rst_n), .polarity(polarity),
        .cwdi(di_v[0]), .cwsi(si_v[0]), .cwri(cwri),
        .ccwdi(di_v[1]), .ccwsi(si_v[1]), .ccwri(ccwri),
        .pedi(di_v[2]), .pesi(si_v[2]), .peri(peri),
        .cwdo(cwdo), .cwso(cwso), .cwro(ro_v[0]),
        .ccwdo(ccwdo), .ccwso(ccwso), .ccwro(ro_v[1]),
        .pedo(pedo), .peso(peso), .pero(ro_v[2])
    );

    router_checker checker_i (
        .clk(clk), .rst_n(rst_n), .polarity(polarity),
        .so({peso, ccwso, cwso}), .ro(ro_v),
        .cw_dout(cwdo), .ccw_dout(ccwdo), .pe_dout(pedo),
        .exp_valid(exp_valid), .exp_port(exp_port), .exp_data(exp_data),
        .any_order(any_order), .test_end(test_end), .test_name(test_name),
        .pending(pending), .tests_passed(tests_passed), .tests_failed(tests_failed)
    );

    // ready levels, indexed like the port enum
    assign ri_v = {peri, ccwri, cwri};

    always #10 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run exceeded %0d cycles", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic ring_pkg::flit_t make_flit(input logic dir, input logic [7:0] hop,
                                                  input logic [47:0] payload);
        ring_pkg::flit_t f;
        f = '0;
        f[ring_pkg::DIR_BIT] = dir;
        f[ring_pkg::HOP_LSB +: ring_pkg::HOP_W] = hop;
        f[47:0] = payload;
        return f;
    endfunction

    // stamp, injection rewrite, one hop shift
    function automatic ring_pkg::flit_t expected_flit(input int src, input ring_pkg::flit_t pkt,
                                                      input logic pol);
        ring_pkg::flit_t f;
        logic [7:0]      hop;
        f = pkt;
        f[ring_pkg::POL_BIT] = pol;
        hop = f[ring_pkg::HOP_LSB +: ring_pkg::HOP_W];
        if (src == 2) begin
            if (hop == 8'h03) begin
                f[ring_pkg::DIR_BIT] = 1'b1;
            end else if (hop == 8'h07) begin
                f[ring_pkg::DIR_BIT] = ~f[ring_pkg::DIR_BIT];
                hop = 8'h01;
            end
        end
        f[ring_pkg::HOP_LSB +: ring_pkg::HOP_W] = hop >> 1;
        return f;
    endfunction

    task automatic add_entry(input logic [8*16-1:0] name, input ring_pkg::port_e src,
                             input ring_pkg::flit_t pkt, input int hold,
                             input ring_pkg::port_e dest, input bit drop, input bit nxt,
                             input bit any, input bit bp);
        t_name[n_entries] = name;
        t_port[n_entries] = src;
        t_pkt[n_entries]  = pkt;
        t_hold[n_entries] = hold;
        t_dest[n_entries] = dest;
        t_drop[n_entries] = drop;
        t_next[n_entries] = nxt;
        t_any[n_entries]  = any;
        t_bp[n_entries]   = bp;
        n_entries++;
    endtask

    task automatic build_table();
        // two cw packets back to back, both planes
        add_entry("cw_through", ring_pkg::PORT_CW, make_flit(1, 8'h03, 48'h11), 0,
                  ring_pkg::PORT_CW, 0, 1, 0, 0);
        add_entry("cw_through", ring_pkg::PORT_CW, make_flit(1, 8'h01, 48'h12), 0,
                  ring_pkg::PORT_CW, 0, 0, 0, 0);
        add_entry("ccw_eject", ring_pkg::PORT_CCW, make_flit(0, 8'h02, 48'h21), 0,
                  ring_pkg::PORT_PE, 0, 0, 0, 0);
        add_entry("pe_hop_one", ring_pkg::PORT_PE, make_flit(0, 8'h01, 48'h31), 0,
                  ring_pkg::PORT_CCW, 0, 0, 0, 0);
        // forced clockwise
        add_entry("pe_hop_two", ring_pkg::PORT_PE, make_flit(0, 8'h03, 48'h32), 0,
                  ring_pkg::PORT_CW, 0, 0, 0, 0);
        // inverted direction, one hop
        add_entry("pe_hop_three", ring_pkg::PORT_PE, make_flit(1, 8'h07, 48'h33), 0,
                  ring_pkg::PORT_CCW, 0, 0, 0, 0);
        // three bad codes behind a low cwro
        // an accepted one would stall the pe input
        add_entry("pe_bad_hop", ring_pkg::PORT_PE, make_flit(1, 8'h05, 48'h34), 8,
                  ring_pkg::PORT_CW, 1, 1, 0, 0);
        add_entry("pe_bad_hop", ring_pkg::PORT_PE, make_flit(1, 8'h00, 48'h35), 8,
                  ring_pkg::PORT_CW, 1, 1, 0, 0);
        add_entry("pe_bad_hop", ring_pkg::PORT_PE, make_flit(1, 8'hff, 48'h36), 8,
                  ring_pkg::PORT_CW, 1, 0, 0, 0);
        // four packets fill both planes while cwro is low
        for (int i = 0; i < 4; i++) begin
            add_entry("cw_backpressure", ring_pkg::PORT_CW, make_flit(1, 8'h0f, 48'h40 + i),
                      8, ring_pkg::PORT_CW, 0, i < 3, 0, 1);
        end
        add_entry("cw_contention", ring_pkg::PORT_CW, make_flit(1, 8'h01, 48'h51), 0,
                  ring_pkg::PORT_CW, 0, 1, 1, 0);
        add_entry("cw_contention", ring_pkg::PORT_PE, make_flit(1, 8'h01, 48'h52), 0,
                  ring_pkg::PORT_CW, 0, 0, 1, 0);
    endtask

    // one cycle, inputs change on the falling edge
    task automatic tick();
        @(negedge clk);
        polarity = ~polarity;
        si_v = '0;
        exp_valid = '0;
        test_end = 1'b0;
    endtask

    task automatic run_group(input int first, input int last);
        int  cyc;
        int  hold;
        int  min_win;
        int  pick [3];
        bit  all_sent;
        bit  cwri_low;
        cyc = 0;
        cwri_low = 1'b0;
        // even hold, release starts on the plane of the first packet
        hold = t_hold[first] + 2 * int'($unsigned($random(seed)) % 4);
        min_win = t_drop[first] ? 12 : 0;
        any_order = t_any[first];
        for (int e = first; e <= last; e++) begin
            sent[e] = 1'b0;
        end
        forever begin
            tick();
            all_sent = 1'b1;
            for (int e = first; e <= last; e++) begin
                if (!sent[e]) all_sent = 1'b0;
            end
            if ((all_sent && pending == 0 && cyc >= hold && cyc >= min_win) || cyc >= 40) begin
                break;
            end
            ro_v = (cyc >= hold) ? 3'b111 : 3'b000;
            // oldest unsent packet per input port
            for (int p = 0; p < 3; p++) begin
                pick[p] = -1;
                for (int e = first; e <= last; e++) begin
                    if (!sent[e] && int'(t_port[e]) == p && pick[p] < 0) pick[p] = e;
                end
                if (pick[p] >= 0) begin
                    si_v[p] = 1'b1;
                    di_v[p] = t_pkt[pick[p]];
                end
            end
            #1;
            for (int p = 0; p < 3; p++) begin
                if (pick[p] >= 0 && ri_v[p]) begin
                    sent[pick[p]] = 1'b1;
                    if (!t_drop[pick[p]]) begin
                        exp_valid[p] = 1'b1;
                        exp_port[p] = t_dest[pick[p]];
                        exp_data[p] = expected_flit(p, t_pkt[pick[p]], polarity);
                    end
                end
            end
            if (t_bp[first] && !cwri) cwri_low = 1'b1;
            if (t_drop[first] && !peri) begin
                $display("peri went low at %0t ns after a dropped packet", $time);
                tb_errors++;
            end
            cyc++;
        end
        if (t_bp[first] && !cwri_low) begin
            $display("cwri never dropped while cwro was held low");
            tb_errors++;
        end
        ro_v = 3'b111;
        test_name = t_name[first];
        test_end = 1'b1;
        tick();
    endtask

    initial begin
        int first;
        clk = 1'b0;
        rst_n = 1'b0;
        polarity = 1'b0;
        si_v = '0;
        ro_v = 3'b111;
        for (int p = 0; p < 3; p++) di_v[p] = '0;
        exp_valid = '0;
        exp_port = '0;
        exp_data = '0;
        any_order = 1'b0;
        test_end = 1'b0;
        test_name = '0;
        seed = 49;
        cycles = 0;
        tb_errors = 0;
        n_entries = 0;
        build_table();
        repeat (16) @(negedge clk);
        // every slot starts out empty
        if (ri_v != 3'b111) begin
            $display("Error at %0t ns: {peri, ccwri, cwri} expected 111 got %b",
                     $time, ri_v);
            tb_errors++;
        end
        if ({peso, ccwso, cwso} != 3'b000) begin
            $display("Error at %0t ns: {peso, ccwso, cwso} expected 000 got %b",
                     $time, {peso, ccwso, cwso});
            tb_errors++;
        end
        rst_n = 1'b1;
        first = 0;
        for (int e = 0; e < n_entries; e++) begin
            if (!t_next[e]) begin
                run_group(first, e);
                first = e + 1;
            end
        end
        tick();
        $display("tests passed %0d, tests failed %0d, other errors %0d",
                 tests_passed, tests_failed, tb_errors);
        if (tests_failed == 0 && tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: list.f
source/ring_pkg.sv
source/plane_link_if.sv
source/slot_buffer.sv
source/rr_arbiter.sv
source/vc_plane.sv
source/phase_steer.sv
source/gold_router.sv
sim/router_checker.sv
sim/tb_router.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_router \
    -f list.f -o sim_router

out=$(./obj_dir/sim_router)
echo "$out"

if grep -q "Simulation completed successfully" <<< "$out"; then
    exit 0
else
    exit 1
fi
